//--- hw/trace_pkg.sv
/*
 * Retirement tracer shared definitions
 * Widths, mnemonic and format encodings, access flags and the records
 * passed between the capture, decode and emit stages
 */
package trace_pkg;

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;

  // RV32 major opcodes, low two bits always 11
  typedef enum logic [6:0] {
    OPC_LOAD     = 7'b0000011,
    OPC_MISC_MEM = 7'b0001111,
    OPC_OP_IMM   = 7'b0010011,
    OPC_AUIPC    = 7'b0010111,
    OPC_STORE    = 7'b0100011,
    OPC_OP       = 7'b0110011,
    OPC_LUI      = 7'b0110111,
    OPC_BRANCH   = 7'b1100011,
    OPC_JALR     = 7'b1100111,
    OPC_JAL      = 7'b1101111,
    OPC_SYSTEM   = 7'b1110011
  } rv_opcode_e;

  typedef enum logic [5:0] {
    OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
    OP_SB, OP_SH, OP_SW,
    OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
    OP_SLLI, OP_SRLI, OP_SRAI,
    OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
    OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
    OP_FENCE, OP_FENCE_I,
    OP_ECALL, OP_EBREAK, OP_MRET, OP_DRET, OP_WFI,
    OP_CSRRW, OP_CSRRS, OP_CSRRC, OP_CSRRWI, OP_CSRRSI, OP_CSRRCI,
    OP_INVALID
  } trace_op_e;

  typedef enum logic [2:0] {
    FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J, FMT_CSR, FMT_NONE
  } insn_fmt_e;

  typedef struct packed {
    logic rs1;
    logic rs2;
    logic rd;
    logic mem;
  } access_mask_t;

  // Access patterns per instruction class
  localparam access_mask_t ACC_NONE   = '{rs1: 1'b0, rs2: 1'b0, rd: 1'b0, mem: 1'b0};
  localparam access_mask_t ACC_R      = '{rs1: 1'b1, rs2: 1'b1, rd: 1'b1, mem: 1'b0};
  localparam access_mask_t ACC_I      = '{rs1: 1'b1, rs2: 1'b0, rd: 1'b1, mem: 1'b0};
  localparam access_mask_t ACC_LOAD   = '{rs1: 1'b1, rs2: 1'b0, rd: 1'b1, mem: 1'b1};
  localparam access_mask_t ACC_STORE  = '{rs1: 1'b1, rs2: 1'b1, rd: 1'b0, mem: 1'b1};
  localparam access_mask_t ACC_BRANCH = '{rs1: 1'b1, rs2: 1'b1, rd: 1'b0, mem: 1'b0};
  localparam access_mask_t ACC_RD     = '{rs1: 1'b0, rs2: 1'b0, rd: 1'b1, mem: 1'b0};

  typedef struct packed {
    logic [XLEN-1:0]       insn;
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_rdata;
    logic [XLEN-1:0]       rs2_rdata;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       rd_wdata;
    logic [XLEN-1:0]       mem_addr;
    logic [XLEN/8-1:0]     mem_rmask;
    logic [XLEN/8-1:0]     mem_wmask;
    logic [XLEN-1:0]       mem_rdata;
    logic [XLEN-1:0]       mem_wdata;
  } rvfi_retire_t;

  typedef struct packed {
    rvfi_retire_t retire;
    logic [31:0]  cycle;
  } capt_t;

  typedef struct packed {
    capt_t           capt;
    trace_op_e       op;
    insn_fmt_e       fmt;
    access_mask_t    access;
    logic [XLEN-1:0] imm;
  } dec_t;

  typedef struct packed {
    logic [31:0]           cycle;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       insn;
    trace_op_e             op;
    insn_fmt_e             fmt;
    access_mask_t          access;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       target;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs2_data;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       rd_data;
    logic [XLEN-1:0]       mem_addr;
    logic [XLEN-1:0]       mem_data;
  } trace_rec_t;

endpackage

//--- hw/rvfi_capture.sv
/*
 * Retirement capture stage
 * Registers each accepted RVFI retirement with the current cycle count
 */
`timescale 1ns/100ps

module rvfi_capture import trace_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         in_valid,
  input  rvfi_retire_t in_retire,
  output logic         in_ready,
  output logic         capt_valid,
  output capt_t        capt,
  input  logic         capt_ready
);

  logic [31:0] cycle_q;

  // Free-running, 0 in the first cycle out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_q <= '0;
    end else begin
      cycle_q <= cycle_q + 32'd1;
    end
  end

  // Empty, or the held item leaves this cycle
  assign in_ready = !capt_valid || capt_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      capt_valid <= 1'b0;
    end else if (in_ready) begin
      capt_valid <= in_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid && in_ready) begin
      capt.retire <= in_retire;
      capt.cycle  <= cycle_q;
    end
  end

  // Held item must not change while the decoder stalls
  a_capt_hold: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    capt_valid && !capt_ready |=> capt_valid && $stable(capt)
  );

endmodule

//--- hw/insn_decoder.sv
/*
 * RV32I instruction decode stage
 * Derives mnemonic, format, register and memory access flags and the
 * immediate, and registers them with the captured retirement
 */
`timescale 1ns/100ps

module insn_decoder import trace_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  capt_valid,
  input  capt_t capt,
  output logic  capt_ready,
  output logic  dec_valid,
  output dec_t  dec,
  input  logic  dec_ready
);

  logic [XLEN-1:0] insn;
  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm_shamt;
  logic [XLEN-1:0] imm_csr;

  trace_op_e       op_d;
  insn_fmt_e       fmt_d;
  access_mask_t    acc_d;
  logic [XLEN-1:0] imm_d;

  assign insn   = capt.retire.insn;
  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  assign imm_i     = {{20{insn[31]}}, insn[31:20]};
  assign imm_s     = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b     = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u     = {insn[31:12], 12'b0};
  assign imm_j     = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_shamt = {27'b0, insn[24:20]};
  assign imm_csr   = {20'b0, insn[31:20]};

  // Compressed words never match, as every listed opcode ends in 11
  always_comb begin
    op_d  = OP_INVALID;
    fmt_d = FMT_NONE;
    acc_d = ACC_NONE;
    imm_d = '0;

    case (opcode)
      OPC_LUI: begin
        op_d  = OP_LUI;
        fmt_d = FMT_U;
        acc_d = ACC_RD;
        imm_d = imm_u;
      end
      OPC_AUIPC: begin
        op_d  = OP_AUIPC;
        fmt_d = FMT_U;
        acc_d = ACC_RD;
        imm_d = imm_u;
      end
      OPC_JAL: begin
        op_d  = OP_JAL;
        fmt_d = FMT_J;
        acc_d = ACC_RD;
        imm_d = imm_j;
      end
      OPC_JALR: begin
        op_d  = (funct3 == 3'b000) ? OP_JALR : OP_INVALID;
        fmt_d = FMT_I;
        acc_d = ACC_I;
        imm_d = imm_i;
      end
      OPC_BRANCH: begin
        fmt_d = FMT_B;
        acc_d = ACC_BRANCH;
        imm_d = imm_b;
        case (funct3)
          3'b000:  op_d = OP_BEQ;
          3'b001:  op_d = OP_BNE;
          3'b100:  op_d = OP_BLT;
          3'b101:  op_d = OP_BGE;
          3'b110:  op_d = OP_BLTU;
          3'b111:  op_d = OP_BGEU;
          default: op_d = OP_INVALID;
        endcase
      end
      OPC_LOAD: begin
        fmt_d = FMT_I;
        acc_d = ACC_LOAD;
        imm_d = imm_i;
        case (funct3)
          3'b000:  op_d = OP_LB;
          3'b001:  op_d = OP_LH;
          3'b010:  op_d = OP_LW;
          3'b100:  op_d = OP_LBU;
          3'b101:  op_d = OP_LHU;
          default: op_d = OP_INVALID;
        endcase
      end
      OPC_STORE: begin
        fmt_d = FMT_S;
        acc_d = ACC_STORE;
        imm_d = imm_s;
        case (funct3)
          3'b000:  op_d = OP_SB;
          3'b001:  op_d = OP_SH;
          3'b010:  op_d = OP_SW;
          default: op_d = OP_INVALID;
        endcase
      end
      OPC_OP_IMM: begin
        fmt_d = FMT_I;
        acc_d = ACC_I;
        imm_d = imm_i;
        case (funct3)
          3'b000:  op_d = OP_ADDI;
          3'b010:  op_d = OP_SLTI;
          3'b011:  op_d = OP_SLTIU;
          3'b100:  op_d = OP_XORI;
          3'b110:  op_d = OP_ORI;
          3'b111:  op_d = OP_ANDI;
          default: op_d = OP_INVALID;
        endcase
        // Shifts carry only the shamt
        if (funct3 == 3'b001 || funct3 == 3'b101) begin
          imm_d = imm_shamt;
          case ({funct7, funct3})
            10'b0000000_001: op_d = OP_SLLI;
            10'b0000000_101: op_d = OP_SRLI;
            10'b0100000_101: op_d = OP_SRAI;
            default:         op_d = OP_INVALID;
          endcase
        end
      end
      OPC_OP: begin
        fmt_d = FMT_R;
        acc_d = ACC_R;
        case ({funct7, funct3})
          10'b0000000_000: op_d = OP_ADD;
          10'b0100000_000: op_d = OP_SUB;
          10'b0000000_001: op_d = OP_SLL;
          10'b0000000_010: op_d = OP_SLT;
          10'b0000000_011: op_d = OP_SLTU;
          10'b0000000_100: op_d = OP_XOR;
          10'b0000000_101: op_d = OP_SRL;
          10'b0100000_101: op_d = OP_SRA;
          10'b0000000_110: op_d = OP_OR;
          10'b0000000_111: op_d = OP_AND;
          default:         op_d = OP_INVALID;
        endcase
      end
      OPC_MISC_MEM: begin
        case (funct3)
          3'b000:  op_d = OP_FENCE;
          3'b001:  op_d = OP_FENCE_I;
          default: op_d = OP_INVALID;
        endcase
      end
      OPC_SYSTEM: begin
        case (funct3)
          3'b000: begin
            case (insn)
              32'h0000_0073: op_d = OP_ECALL;
              32'h0010_0073: op_d = OP_EBREAK;
              32'h3020_0073: op_d = OP_MRET;
              32'h7b20_0073: op_d = OP_DRET;
              32'h1050_0073: op_d = OP_WFI;
              default:       op_d = OP_INVALID;
            endcase
          end
          3'b001:  op_d = OP_CSRRW;
          3'b010:  op_d = OP_CSRRS;
          3'b011:  op_d = OP_CSRRC;
          3'b101:  op_d = OP_CSRRWI;
          3'b110:  op_d = OP_CSRRSI;
          3'b111:  op_d = OP_CSRRCI;
          default: op_d = OP_INVALID;
        endcase
        if (funct3 != 3'b000) begin
          fmt_d = FMT_CSR;
          imm_d = imm_csr;
          // funct3[2] selects the uimm source in place of rs1
          acc_d = funct3[2] ? ACC_RD : ACC_I;
        end
      end
      default: op_d = OP_INVALID;
    endcase

    // Unlisted encoding inside a known opcode
    if (op_d == OP_INVALID) begin
      fmt_d = FMT_NONE;
      acc_d = ACC_NONE;
      imm_d = '0;
    end
  end

  assign capt_ready = !dec_valid || dec_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec_valid <= 1'b0;
    end else if (capt_ready) begin
      dec_valid <= capt_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capt_valid && capt_ready) begin
      dec.capt   <= capt;
      dec.op     <= op_d;
      dec.fmt    <= fmt_d;
      dec.access <= acc_d;
      dec.imm    <= imm_d;
    end
  end

  a_mem_only_ldst: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    dec_valid && dec.access.mem |->
      dec.op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW}
  );

endmodule

//--- hw/trace_emitter.sv
/*
 * Trace record output stage
 * Computes jump and branch targets, clears fields that were not accessed
 * and holds the record until the consumer takes it
 */
`timescale 1ns/100ps

module trace_emitter import trace_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       dec_valid,
  input  dec_t       dec,
  output logic       dec_ready,
  output logic       out_valid,
  output trace_rec_t out_rec,
  input  logic       out_ready
);

  rvfi_retire_t    ret;
  logic [XLEN-1:0] target_d;
  logic [XLEN-1:0] mem_data_d;
  trace_rec_t      rec_d;

  assign ret = dec.capt.retire;

  always_comb begin
    target_d = '0;
    if (dec.fmt == FMT_B || dec.op == OP_JAL) begin
      target_d = ret.pc + dec.imm;
    end else if (dec.op == OP_JALR) begin
      target_d = (ret.rs1_rdata + dec.imm) & ~32'd1;
    end
  end

  // Load data wins when both masks are set
  always_comb begin
    mem_data_d = '0;
    if (ret.mem_rmask != '0) begin
      mem_data_d = ret.mem_rdata;
    end else if (ret.mem_wmask != '0) begin
      mem_data_d = ret.mem_wdata;
    end
  end

  always_comb begin
    rec_d.cycle    = dec.capt.cycle;
    rec_d.pc       = ret.pc;
    rec_d.insn     = ret.insn;
    rec_d.op       = dec.op;
    rec_d.fmt      = dec.fmt;
    rec_d.access   = dec.access;
    rec_d.imm      = dec.imm;
    rec_d.target   = target_d;
    rec_d.rs1_addr = dec.access.rs1 ? ret.rs1_addr  : '0;
    rec_d.rs1_data = dec.access.rs1 ? ret.rs1_rdata : '0;
    rec_d.rs2_addr = dec.access.rs2 ? ret.rs2_addr  : '0;
    rec_d.rs2_data = dec.access.rs2 ? ret.rs2_rdata : '0;
    rec_d.rd_addr  = dec.access.rd  ? ret.rd_addr   : '0;
    rec_d.rd_data  = dec.access.rd  ? ret.rd_wdata  : '0;
    rec_d.mem_addr = dec.access.mem ? ret.mem_addr  : '0;
    rec_d.mem_data = mem_data_d;
  end

  assign dec_ready = !out_valid || out_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid <= 1'b0;
    end else if (dec_ready) begin
      out_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_valid && dec_ready) begin
      out_rec <= rec_d;
    end
  end

  // Record and valid both held while the consumer stalls
  a_out_hold: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    out_valid && !out_ready |=> out_valid && $stable(out_rec)
  );

endmodule

//--- hw/rvfi_tracer.sv
/*
 * RVFI retirement tracer
 * Capture, decode and emit stages in a three-deep valid/ready pipeline
 */
`timescale 1ns/100ps

module rvfi_tracer import trace_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         in_valid,
  input  rvfi_retire_t in_retire,
  output logic         in_ready,
  output logic         out_valid,
  output trace_rec_t   out_rec,
  input  logic         out_ready
);

  logic  capt_valid;
  logic  capt_ready;
  capt_t capt;

  logic  dec_valid;
  logic  dec_ready;
  dec_t  dec;

  rvfi_capture i_capture (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .in_valid   (in_valid),
    .in_retire  (in_retire),
    .in_ready   (in_ready),
    .capt_valid (capt_valid),
    .capt       (capt),
    .capt_ready (capt_ready)
  );

  insn_decoder i_decoder (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .capt_valid (capt_valid),
    .capt       (capt),
    .capt_ready (capt_ready),
    .dec_valid  (dec_valid),
    .dec        (dec),
    .dec_ready  (dec_ready)
  );

  trace_emitter i_emitter (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .dec_valid (dec_valid),
    .dec       (dec),
    .dec_ready (dec_ready),
    .out_valid (out_valid),
    .out_rec   (out_rec),
    .out_ready (out_ready)
  );

endmodule

//--- tests/tb_rvfi_tracer.sv
/*
 * RVFI tracer testbench
 * Applies a table of retirements under random back-pressure, then back to
 * back, and checks every trace record, its cycle stamp and the latency
 */
`timescale 1ns/100ps

module tb_rvfi_tracer import trace_pkg::*; ();

  localparam logic [31:0] SEED = 32'h4be816b4;

  typedef struct {
    string        name;
    logic [31:0]  insn;
    logic [31:0]  pc;
    logic [31:0]  rs1_data;
    logic [7:0]   masks;
    trace_op_e    op;
    insn_fmt_e    fmt;
    access_mask_t acc;
    logic [31:0]  imm;
    logic [31:0]  target;
  } vec_t;

  logic         clk_i      = 1'b0;
  logic         rst_ni     = 1'b0;
  logic         in_valid   = 1'b0;
  rvfi_retire_t in_retire  = '0;
  logic         out_ready  = 1'b0;
  logic         in_ready;
  logic         out_valid;
  trace_rec_t   out_rec;

  logic         hold_ready = 1'b0;
  logic [31:0]  lcg_q      = SEED;
  logic [31:0]  tb_cycle   = '0;
  logic [31:0]  prev_out   = '0;
  logic [31:0]  stamps[$];
  vec_t         vecs[$];
  int           out_count  = 0;
  int           run_cycles = 0;
  int           limit      = 1000;

  rvfi_tracer i_dut (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .in_valid  (in_valid),
    .in_retire (in_retire),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_rec   (out_rec),
    .out_ready (out_ready)
  );

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic add_vec(input string name, input logic [31:0] insn, input logic [31:0] pc,
                         input logic [31:0] rs1_data, input logic [7:0] masks,
                         input trace_op_e op, input insn_fmt_e fmt, input access_mask_t acc,
                         input logic [31:0] imm, input logic [31:0] target);
    vec_t v;
    v = '{name, insn, pc, rs1_data, masks, op, fmt, acc, imm, target};
    vecs.push_back(v);
  endtask

  // Register addresses come from the instruction fields, data from the index
  function automatic rvfi_retire_t retire_for(input int idx);
    rvfi_retire_t r;
    vec_t         v;
    v           = vecs[idx];
    r.insn      = v.insn;
    r.pc        = v.pc;
    r.rs1_addr  = v.insn[19:15];
    r.rs2_addr  = v.insn[24:20];
    r.rd_addr   = v.insn[11:7];
    r.rs1_rdata = v.rs1_data;
    r.rs2_rdata = 32'hb000_0000 + 32'(idx);
    r.rd_wdata  = 32'hd000_0000 + 32'(idx);
    r.mem_addr  = 32'h2000_0100 + 32'(4 * idx);
    r.mem_rmask = v.masks[7:4];
    r.mem_wmask = v.masks[3:0];
    r.mem_rdata = 32'h5a5a_0000 + 32'(idx);
    r.mem_wdata = 32'ha5a5_0000 + 32'(idx);
    return r;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAIL %s: expected 0x%08h, actual 0x%08h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "Value check failed");
    end
  endtask

  task automatic check_record(input int k, input logic [31:0] stamp, input trace_rec_t r);
    int           idx;
    vec_t         v;
    rvfi_retire_t s;
    logic [31:0]  exp_mem;
    string        tn;
    idx     = k % vecs.size();
    v       = vecs[idx];
    s       = retire_for(idx);
    tn      = $sformatf("%s (record %0d)", v.name, k);
    exp_mem = '0;
    if (s.mem_rmask != '0) begin
      exp_mem = s.mem_rdata;
    end else if (s.mem_wmask != '0) begin
      exp_mem = s.mem_wdata;
    end
    check_val({tn, " cycle"}, stamp, r.cycle);
    check_val({tn, " pc"}, s.pc, r.pc);
    check_val({tn, " insn"}, s.insn, r.insn);
    check_val({tn, " op"}, 32'(v.op), 32'(r.op));
    check_val({tn, " fmt"}, 32'(v.fmt), 32'(r.fmt));
    check_val({tn, " access"}, 32'(v.acc), 32'(r.access));
    check_val({tn, " imm"}, v.imm, r.imm);
    check_val({tn, " target"}, v.target, r.target);
    check_val({tn, " rs1_addr"}, v.acc.rs1 ? 32'(s.rs1_addr) : 32'd0, 32'(r.rs1_addr));
    check_val({tn, " rs1_data"}, v.acc.rs1 ? s.rs1_rdata : 32'd0, r.rs1_data);
    check_val({tn, " rs2_addr"}, v.acc.rs2 ? 32'(s.rs2_addr) : 32'd0, 32'(r.rs2_addr));
    check_val({tn, " rs2_data"}, v.acc.rs2 ? s.rs2_rdata : 32'd0, r.rs2_data);
    check_val({tn, " rd_addr"}, v.acc.rd ? 32'(s.rd_addr) : 32'd0, 32'(r.rd_addr));
    check_val({tn, " rd_data"}, v.acc.rd ? s.rd_wdata : 32'd0, r.rd_data);
    check_val({tn, " mem_addr"}, v.acc.mem ? s.mem_addr : 32'd0, r.mem_addr);
    check_val({tn, " mem_data"}, exp_mem, r.mem_data);
  endtask

  // Holds valid and data until the transfer, gaps come from the LCG
  task automatic drive_pass(input bit gaps);
    int idx;
    idx = 0;
    while (idx < vecs.size()) begin
      @(posedge clk_i);
      if (in_valid && in_ready) begin
        idx++;
      end
      if (idx == vecs.size()) begin
        in_valid <= 1'b0;
      end else if (!in_valid || in_ready) begin
        in_valid  <= !gaps || lcg_q[24];
        in_retire <= retire_for(idx);
      end
    end
  endtask

  always @(posedge clk_i) begin
    lcg_q     <= rst_ni ? lcg_next(lcg_q) : SEED;
    out_ready <= hold_ready || lcg_q[16];
  end

  // Reads 0 in the first cycle after reset release, like the DUT counter
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      tb_cycle <= '0;
    end else begin
      tb_cycle <= tb_cycle + 32'd1;
    end
  end

  always @(posedge clk_i) begin
    run_cycles <= run_cycles + 1;
    if (run_cycles >= limit) begin
      $display("TEST FAILED");
      $fatal(1, "Timeout after %0d cycles before all trace records arrived", run_cycles);
    end
  end

  always @(posedge clk_i) begin
    logic [31:0] stamp;
    if (rst_ni) begin
      if (in_valid && in_ready) begin
        stamps.push_back(tb_cycle);
      end
      if (out_valid && out_ready) begin
        if (stamps.size() == 0) begin
          $display("TEST FAILED");
          $fatal(1, "Trace record came out with no matching input");
        end else begin
          stamp = stamps.pop_front();
          check_record(out_count, stamp, out_rec);
          // Second pass runs with out_ready high and no input gaps
          if (out_count >= vecs.size()) begin
            check_val("latency", stamp + 32'd3, tb_cycle);
          end
          if (out_count > vecs.size()) begin
            check_val("throughput", prev_out + 32'd1, tb_cycle);
          end
          prev_out  <= tb_cycle;
          out_count <= out_count + 1;
        end
      end
    end
  end

  initial begin
    add_vec("add",    32'h002081b3, 32'h8000_0000, 32'h0000_1234, 8'h00,
            OP_ADD,     FMT_R,    4'b1110, 32'h0000_0000, 32'h0000_0000);
    add_vec("addi",   32'hff430293, 32'h8000_0004, 32'h1000_0001, 8'h00,
            OP_ADDI,    FMT_I,    4'b1010, 32'hffff_fff4, 32'h0000_0000);
    add_vec("slli",   32'h00d41393, 32'h8000_0008, 32'h1000_0002, 8'h00,
            OP_SLLI,    FMT_I,    4'b1010, 32'h0000_000d, 32'h0000_0000);
    add_vec("lui",    32'habcde537, 32'h8000_000c, 32'h1000_0003, 8'h00,
            OP_LUI,     FMT_U,    4'b0010, 32'habcd_e000, 32'h0000_0000);
    add_vec("jal",    32'h001000ef, 32'h8000_0010, 32'h1000_0004, 8'h00,
            OP_JAL,     FMT_J,    4'b0010, 32'h0000_0800, 32'h8000_0810);
    add_vec("jalr",   32'h005600e7, 32'h8000_0014, 32'h8000_2000, 8'h00,
            OP_JALR,    FMT_I,    4'b1010, 32'h0000_0005, 32'h8000_2004);
    add_vec("bne",    32'hfee698e3, 32'h8000_0018, 32'h1000_0006, 8'h00,
            OP_BNE,     FMT_B,    4'b1100, 32'hffff_fff0, 32'h8000_0008);
    add_vec("lw",     32'h00882783, 32'h8000_001c, 32'h1000_0007, 8'hf0,
            OP_LW,      FMT_I,    4'b1011, 32'h0000_0008, 32'h0000_0000);
    add_vec("sh",     32'hff191f23, 32'h8000_0020, 32'h1000_0008, 8'h03,
            OP_SH,      FMT_S,    4'b1101, 32'hffff_fffe, 32'h0000_0000);
    add_vec("csrrs",  32'hb00a29f3, 32'h8000_0024, 32'h1000_0009, 8'h00,
            OP_CSRRS,   FMT_CSR,  4'b1010, 32'h0000_0b00, 32'h0000_0000);
    add_vec("csrrwi", 32'h3403daf3, 32'h8000_0028, 32'h1000_000a, 8'h00,
            OP_CSRRWI,  FMT_CSR,  4'b0010, 32'h0000_0340, 32'h0000_0000);
    add_vec("fence",  32'h0ff0000f, 32'h8000_002c, 32'h1000_000b, 8'h00,
            OP_FENCE,   FMT_NONE, 4'b0000, 32'h0000_0000, 32'h0000_0000);
    add_vec("c_addi", 32'h12340505, 32'h8000_0030, 32'h1000_000c, 8'h00,
            OP_INVALID, FMT_NONE, 4'b0000, 32'h0000_0000, 32'h0000_0000);
    add_vec("unused", 32'h1234567b, 32'h8000_0034, 32'h1000_000d, 8'h00,
            OP_INVALID, FMT_NONE, 4'b0000, 32'h0000_0000, 32'h0000_0000);
    limit = 20 * 2 * vecs.size() + 100;

    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    check_val("reset out_valid", 32'd0, 32'(out_valid));
    check_val("reset in_ready", 32'd1, 32'(in_ready));

    drive_pass(1'b1);
    while (out_count < vecs.size()) @(posedge clk_i);
    hold_ready <= 1'b1;
    repeat (3) @(posedge clk_i);
    drive_pass(1'b0);
    while (out_count < 2 * vecs.size()) @(posedge clk_i);
    repeat (4) @(posedge clk_i);

    if (out_count == 2 * vecs.size() && stamps.size() == 0 && !out_valid) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1, "Extra trace records after the last entry");
    end
  end

endmodule

//--- verilog.f
hw/trace_pkg.sv
hw/rvfi_capture.sv
hw/insn_decoder.sv
hw/trace_emitter.sv
hw/rvfi_tracer.sv
tests/tb_rvfi_tracer.sv

//--- Makefile
# Verilator simulation of the RVFI tracer testbench

TOP := tb_rvfi_tracer

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f verilog.f \
		--top-module $(TOP) --Mdir obj_dir -o V$(TOP)

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
